// ==== compile.f ====
+incdir+dv
hdl/rob_pkg.sv
hdl/commit_pkg.sv
hdl/rob_pointer_ctrl.sv
hdl/rob_entry_store.sv
hdl/commit_select.sv
hdl/rob_top.sv
dv/rob_sva.sv
dv/rob_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the ROB testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert --timing -f compile.f --top-module rob_tb \
    -Mdir obj_dir -o rob_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/rob_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
fi

if grep -q "^Testbench passed$" "$LOG"; then
    exit 0
fi
exit 1

// ==== dv/rob_tb_tests.svh ====
// Stimulus helpers and directed tests for the ROB

task automatic clear_alloc();
    alloc_valid_0 = 1'b0;
    alloc_valid_1 = 1'b0;
    alloc_pc_0 = '0;
    alloc_pc_1 = '0;
    alloc_arch_reg_0 = '0;
    alloc_arch_reg_1 = '0;
    alloc_phys_reg_0 = '0;
    alloc_phys_reg_1 = '0;
endtask

task automatic clear_complete();
    complete_valid = 1'b0;
    complete_rob_id = '0;
    complete_result = '0;
    complete_exception = 1'b0;
    complete_exc_code = EXC_NONE;
    complete_mispredict = 1'b0;
    complete_target = '0;
endtask

// Allocate one or two entries for one cycle, stalling while short of credits
task automatic alloc_slots(input int n, input xlen_t pc, input arch_reg_t ar0,
                           input arch_reg_t ar1, input phys_reg_t pr0,
                           output rob_id_t id0, output rob_id_t id1);
    int waited;
    waited = 0;
    @(posedge clk);
    while (credits < n) begin
        if (waited++ > TIMEOUT_CYCLES) fail_now("timeout waiting for allocation credits");
        @(posedge clk);
    end
    #1;
    alloc_valid_0 = 1'b1;
    alloc_valid_1 = (n == 2);
    alloc_pc_0 = pc;
    alloc_pc_1 = pc + 32'd4;
    alloc_arch_reg_0 = ar0;
    alloc_arch_reg_1 = ar1;
    alloc_phys_reg_0 = pr0;
    alloc_phys_reg_1 = pr0 + phys_reg_t'(1);
    credits = credits - n;
    id0 = alloc_rob_id_0;
    id1 = alloc_rob_id_1;
    check_eq("alloc id 0", 32'(exp_tail), 32'(id0));
    check_eq("alloc id 1", 32'(rob_id_t'(exp_tail + 1)), 32'(id1));
    exp_tail = exp_tail + rob_id_t'(n);
    @(posedge clk);
    #1 clear_alloc();
endtask

task automatic complete_entry(input rob_id_t id, input xlen_t res, input logic exc,
                              input exc_code_e code, input logic mis, input xlen_t tgt);
    @(posedge clk);
    #1;
    complete_valid = 1'b1;
    complete_rob_id = id;
    complete_result = res;
    complete_exception = exc;
    complete_exc_code = code;
    complete_mispredict = mis;
    complete_target = tgt;
    @(posedge clk);
    #1 clear_complete();
endtask

task automatic wait_commits(input int n);
    int waited;
    waited = 0;
    while (mon_arch.size() < n) begin
        if (waited++ > TIMEOUT_CYCLES) fail_now("timeout waiting for commits");
        @(posedge clk);
    end
endtask

// All credits home means the ROB is empty again
task automatic wait_idle();
    int waited;
    waited = 0;
    while (credits != ROB_DEPTH) begin
        if (waited++ > TIMEOUT_CYCLES) fail_now("timeout waiting for credits to return");
        @(posedge clk);
    end
    repeat (2) @(posedge clk);
endtask

task automatic start_test();
    mon_arch.delete();
    mon_phys.delete();
    mon_result.delete();
    mon_wen.delete();
    exp_arch.delete();
    exp_phys.delete();
    exp_result.delete();
    ret_total = 0;
    redir_cnt = 0;
    redir_with_slot1 = 1'b0;
endtask

task automatic compare_commits(input string name);
    check_eq({name, " count"}, exp_arch.size(), mon_arch.size());
    foreach (exp_arch[i]) begin
        check_eq({name, " arch"}, 32'(exp_arch[i]), 32'(mon_arch[i]));
        check_eq({name, " phys"}, 32'(exp_phys[i]), 32'(mon_phys[i]));
        check_eq({name, " result"}, exp_result[i], mon_result[i]);
        check_eq({name, " wen"}, 32'(exp_arch[i] != 0), 32'(mon_wen[i]));
    end
endtask

// ======================================================================
// Directed tests
// ======================================================================
task automatic test_in_order();
    rob_id_t ids[8];
    start_test();
    for (int i = 0; i < 8; i += 2) begin
        alloc_slots(2, 32'h100 + 4 * i, arch_reg_t'(i + 1), arch_reg_t'(i + 2),
                    phys_reg_t'(10 + i), ids[i], ids[i + 1]);
    end
    for (int i = 7; i >= 0; i--) begin
        complete_entry(ids[i], 32'hA000 + i, 1'b0, EXC_NONE, 1'b0, '0);
        exp_arch.push_front(arch_reg_t'(i + 1));
        exp_phys.push_front(phys_reg_t'(10 + i));
        exp_result.push_front(32'hA000 + i);
    end
    wait_commits(8);
    wait_idle();
    compare_commits("in_order");
endtask

task automatic test_credit_stall();
    rob_id_t ids[ROB_DEPTH];
    start_test();
    for (int i = 0; i < ROB_DEPTH; i += 2) begin
        alloc_slots(2, 32'h200 + 4 * i, 5'd7, 5'd8, 6'd20, ids[i], ids[i + 1]);
    end
    check_eq("credit_stall credits", 0, credits);
    // Nothing has completed, so no credit may come back
    repeat (4) @(posedge clk);
    check_eq("credit_stall held", 0, credits);
    for (int i = 0; i < ROB_DEPTH; i++) begin
        complete_entry(ids[i], 32'h5000 + i, 1'b0, EXC_NONE, 1'b0, '0);
    end
    wait_idle();
    check_eq("credit_stall returned", ROB_DEPTH, ret_total);
    check_eq("credit_stall commits", ROB_DEPTH, mon_arch.size());
endtask

task automatic test_x0_no_write();
    rob_id_t id0;
    rob_id_t id1;
    start_test();
    alloc_slots(1, 32'h300, 5'd0, 5'd0, 6'd33, id0, id1);
    complete_entry(id0, 32'hDEAD, 1'b0, EXC_NONE, 1'b0, '0);
    wait_commits(1);
    wait_idle();
    check_eq("x0 commits", 1, mon_arch.size());
    check_eq("x0 wen", 0, 32'(mon_wen[0]));
endtask

task automatic test_exception();
    rob_id_t ids[6];
    start_test();
    for (int i = 0; i < 6; i += 2) begin
        alloc_slots(2, 32'h400 + 4 * i, arch_reg_t'(i + 3), arch_reg_t'(i + 4),
                    phys_reg_t'(40 + i), ids[i], ids[i + 1]);
    end
    for (int i = 5; i >= 3; i--) begin
        complete_entry(ids[i], 32'h600 + i, 1'b0, EXC_NONE, 1'b0, '0);
    end
    complete_entry(ids[0], 32'h600, 1'b0, EXC_NONE, 1'b0, '0);
    complete_entry(ids[1], 32'h601, 1'b0, EXC_NONE, 1'b0, '0);
    complete_entry(ids[2], 32'h602, 1'b1, EXC_LOAD_FAULT, 1'b0, '0);
    wait_idle();
    check_eq("exception commits", 3, mon_arch.size());
    check_eq("exception older 0", 3, 32'(mon_arch[0]));
    check_eq("exception older 1", 4, 32'(mon_arch[1]));
    check_eq("exception faulting wen", 0, 32'(mon_wen[2]));
    check_eq("exception redirects", 1, redir_cnt);
    check_eq("exception kind", 32'(REDIRECT_EXCEPTION), 32'(redir_kind));
    check_eq("exception pc", 32'h408, redir_pc);
    check_eq("exception code", 32'(EXC_LOAD_FAULT), 32'(redir_code));
    check_eq("exception returned", 6, ret_total);
endtask

task automatic test_mispredict();
    rob_id_t id0;
    rob_id_t id1;
    start_test();
    alloc_slots(2, 32'h700, 5'd3, 5'd4, 6'd50, id0, id1);
    complete_entry(id1, 32'h11, 1'b0, EXC_NONE, 1'b0, '0);
    complete_entry(id0, 32'h10, 1'b0, EXC_NONE, 1'b1, 32'h4000);
    wait_idle();
    check_eq("mispredict commits", 1, mon_arch.size());
    check_eq("mispredict slot0 arch", 3, 32'(mon_arch[0]));
    check_eq("mispredict redirects", 1, redir_cnt);
    check_eq("mispredict kind", 32'(REDIRECT_MISPREDICT), 32'(redir_kind));
    check_eq("mispredict pc", 32'h4000, redir_pc);
    check_eq("mispredict alone", 0, 32'(redir_with_slot1));
endtask

// Batches of eight, each completed in a shuffled order
task automatic test_random();
    rob_id_t ids[8];
    xlen_t res[8];
    arch_reg_t ar[8];
    int order[8];
    int j;
    int tmp;
    start_test();
    for (int b = 0; b < 5; b++) begin
        for (int i = 0; i < 8; i += 2) begin
            ar[i] = arch_reg_t'($urandom_range(31, 0));
            ar[i + 1] = arch_reg_t'($urandom_range(31, 0));
            alloc_slots(2, 32'h800 + 4 * i, ar[i], ar[i + 1], phys_reg_t'(i),
                        ids[i], ids[i + 1]);
        end
        for (int i = 0; i < 8; i++) begin
            order[i] = i;
            res[i] = $urandom();
            exp_arch.push_back(ar[i]);
            exp_phys.push_back(phys_reg_t'(i));
            exp_result.push_back(res[i]);
        end
        for (int i = 7; i > 0; i--) begin
            j = $urandom_range(i, 0);
            tmp = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end
        foreach (order[k]) begin
            complete_entry(ids[order[k]], res[order[k]], 1'b0, EXC_NONE, 1'b0, '0);
        end
    end
    wait_commits(40);
    wait_idle();
    compare_commits("random");
endtask

// ==== dv/rob_tb.sv ====
// ROB testbench top with clock, reset, DUT and credit model
// Commit monitor, value check and directed test sequence

module rob_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import rob_pkg::*;
    import commit_pkg::*;

    localparam int TIMEOUT_CYCLES = 2000;

    logic clk;
    logic rst_n;
    logic alloc_valid_0;
    logic alloc_valid_1;
    xlen_t alloc_pc_0;
    xlen_t alloc_pc_1;
    arch_reg_t alloc_arch_reg_0;
    arch_reg_t alloc_arch_reg_1;
    phys_reg_t alloc_phys_reg_0;
    phys_reg_t alloc_phys_reg_1;
    rob_id_t alloc_rob_id_0;
    rob_id_t alloc_rob_id_1;
    rob_count_t credit_return;
    logic complete_valid;
    rob_id_t complete_rob_id;
    xlen_t complete_result;
    logic complete_exception;
    exc_code_e complete_exc_code;
    logic complete_mispredict;
    xlen_t complete_target;
    logic commit_valid_0;
    logic commit_valid_1;
    arch_reg_t commit_arch_reg_0;
    arch_reg_t commit_arch_reg_1;
    phys_reg_t commit_phys_reg_0;
    phys_reg_t commit_phys_reg_1;
    xlen_t commit_result_0;
    xlen_t commit_result_1;
    logic rf_write_en_0;
    logic rf_write_en_1;
    logic redirect_valid;
    redirect_kind_e redirect_kind;
    xlen_t redirect_pc;
    exc_code_e redirect_exc_code;

    // Rename side credit count and observed retirement
    int credits;
    int ret_total;
    int err_count;
    arch_reg_t mon_arch[$];
    phys_reg_t mon_phys[$];
    xlen_t mon_result[$];
    logic mon_wen[$];
    int redir_cnt;
    logic redir_with_slot1;
    redirect_kind_e redir_kind;
    xlen_t redir_pc;
    exc_code_e redir_code;

    // Pointer model that predicts the allocation ids
    rob_id_t exp_head;
    rob_id_t exp_tail;

    // Expected program order
    arch_reg_t exp_arch[$];
    phys_reg_t exp_phys[$];
    xlen_t exp_result[$];

    rob_top dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ======================================================================
    // Monitor, sampled mid-cycle while head state is stable
    // ======================================================================
    always @(negedge clk) begin
        if (rst_n) begin
            if (credit_return != '0) begin
                credits   = credits + int'(credit_return);
                ret_total = ret_total + int'(credit_return);
            end
            if (commit_valid_0) begin
                mon_arch.push_back(commit_arch_reg_0);
                mon_phys.push_back(commit_phys_reg_0);
                mon_result.push_back(commit_result_0);
                mon_wen.push_back(rf_write_en_0);
                exp_head = exp_head + rob_id_t'(1);
            end
            if (commit_valid_1) begin
                mon_arch.push_back(commit_arch_reg_1);
                mon_phys.push_back(commit_phys_reg_1);
                mon_result.push_back(commit_result_1);
                mon_wen.push_back(rf_write_en_1);
                exp_head = exp_head + rob_id_t'(1);
            end
            if (redirect_valid) begin
                redir_cnt++;
                redir_kind = redirect_kind;
                redir_pc   = redirect_pc;
                redir_code = redirect_exc_code;
                if (commit_valid_1) begin
                    redir_with_slot1 = 1'b1;
                end
                // Flush leaves the tail at the new head
                exp_tail = exp_head;
            end
        end
    end

    task automatic fail_now(input string what);
        $display("%s", what);
        $display("Testbench failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            err_count++;
            $display("** Error [%s] expected 0x%0h actual 0x%0h", name, exp, act);
            fail_now("value mismatch");
        end
    endtask

    `include "rob_tb_tests.svh"

    initial begin
        void'($urandom(71));
        rst_n = 1'b0;
        credits = ROB_DEPTH;
        ret_total = 0;
        err_count = 0;
        redir_cnt = 0;
        redir_with_slot1 = 1'b0;
        exp_head = '0;
        exp_tail = '0;
        clear_alloc();
        clear_complete();
        repeat (8) @(posedge clk);
        #1 rst_n = 1'b1;
        test_in_order();
        test_credit_stall();
        test_x0_no_write();
        test_exception();
        test_mispredict();
        test_random();
        if (err_count == 0) begin
            $display("Testbench passed");
            $finish;
        end else begin
            $display("Testbench failed");
            $fatal(1, "errors seen");
        end
    end

endmodule

// ==== dv/rob_sva.sv ====
// Occupancy bound, commit slot rules and post-reset credit checks

module rob_sva (
    input logic                clk,
    input logic                rst_n,
    input rob_pkg::rob_count_t occupancy,
    input rob_pkg::rob_count_t credit_return,
    input logic                commit_valid_0,
    input logic                commit_valid_1,
    input logic                redirect_valid
);
    timeunit 1ns;
    timeprecision 100ps;
    import rob_pkg::*;

    occupancy_bound: assert property (@(posedge clk) disable iff (!rst_n)
        occupancy <= rob_count_t'(ROB_DEPTH))
        else $error("occupancy above depth");

    slot1_needs_slot0: assert property (@(posedge clk) disable iff (!rst_n)
        commit_valid_1 |-> commit_valid_0)
        else $error("slot 1 committed without slot 0");

    redirect_alone: assert property (@(posedge clk) disable iff (!rst_n)
        redirect_valid |-> !commit_valid_1)
        else $error("redirect together with slot 1 commit");

    // First sampled edge after reset release
    credit_quiet_after_reset: assert property (@(posedge clk)
        $rose(rst_n) |-> credit_return == '0)
        else $error("credit return active right after reset");

endmodule

bind rob_pointer_ctrl rob_sva ptr_sva_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .occupancy      (occupancy),
    .credit_return  (credit_return),
    .commit_valid_0 (1'b0),
    .commit_valid_1 (1'b0),
    .redirect_valid (1'b0)
);

bind rob_top rob_sva top_sva_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .occupancy      ('0),
    .credit_return  (credit_return),
    .commit_valid_0 (commit_valid_0),
    .commit_valid_1 (commit_valid_1),
    .redirect_valid (redirect_valid)
);

// ==== hdl/rob_top.sv ====
// Reorder buffer top level
// Connects entry storage, pointer control and commit selection

module rob_top (
    input  logic                       clk,
    input  logic                       rst_n,
    // Allocation from rename
    input  logic                       alloc_valid_0,
    input  logic                       alloc_valid_1,
    input  rob_pkg::xlen_t             alloc_pc_0,
    input  rob_pkg::xlen_t             alloc_pc_1,
    input  rob_pkg::arch_reg_t         alloc_arch_reg_0,
    input  rob_pkg::arch_reg_t         alloc_arch_reg_1,
    input  rob_pkg::phys_reg_t         alloc_phys_reg_0,
    input  rob_pkg::phys_reg_t         alloc_phys_reg_1,
    output rob_pkg::rob_id_t           alloc_rob_id_0,
    output rob_pkg::rob_id_t           alloc_rob_id_1,
    output rob_pkg::rob_count_t        credit_return,
    // Completion from execution
    input  logic                       complete_valid,
    input  rob_pkg::rob_id_t           complete_rob_id,
    input  rob_pkg::xlen_t             complete_result,
    input  logic                       complete_exception,
    input  commit_pkg::exc_code_e      complete_exc_code,
    input  logic                       complete_mispredict,
    input  rob_pkg::xlen_t             complete_target,
    // Retirement
    output logic                       commit_valid_0,
    output logic                       commit_valid_1,
    output rob_pkg::arch_reg_t         commit_arch_reg_0,
    output rob_pkg::arch_reg_t         commit_arch_reg_1,
    output rob_pkg::phys_reg_t         commit_phys_reg_0,
    output rob_pkg::phys_reg_t         commit_phys_reg_1,
    output rob_pkg::xlen_t             commit_result_0,
    output rob_pkg::xlen_t             commit_result_1,
    output logic                       rf_write_en_0,
    output logic                       rf_write_en_1,
    // Front-end redirect
    output logic                       redirect_valid,
    output commit_pkg::redirect_kind_e redirect_kind,
    output rob_pkg::xlen_t             redirect_pc,
    output commit_pkg::exc_code_e      redirect_exc_code
);
    import rob_pkg::*;
    import commit_pkg::*;

    rob_id_t    head_ptr;
    rob_id_t    tail_ptr;
    logic [1:0] retire_count;

    // ======================================================================
    // Head entry fields
    // ======================================================================
    logic       head_valid_0;
    logic       head_valid_1;
    logic       head_ready_0;
    logic       head_ready_1;
    xlen_t      head_pc_0;
    arch_reg_t  head_arch_reg_0;
    arch_reg_t  head_arch_reg_1;
    phys_reg_t  head_phys_reg_0;
    phys_reg_t  head_phys_reg_1;
    xlen_t      head_result_0;
    xlen_t      head_result_1;
    logic       head_exception_0;
    logic       head_exception_1;
    exc_code_e  head_exc_code_0;
    logic       head_mispredict_0;
    logic       head_mispredict_1;
    xlen_t      head_target_0;

    // Rename learns its ids straight from the tail
    assign alloc_rob_id_0 = tail_ptr;
    assign alloc_rob_id_1 = tail_ptr + rob_id_t'(1);

    rob_pointer_ctrl u_pointer_ctrl (
        .flush     (redirect_valid),
        .occupancy (),
        .*
    );

    rob_entry_store u_entry_store (
        .flush (redirect_valid),
        .*
    );

    commit_select u_commit_select (
        .*
    );

endmodule

// ==== hdl/commit_select.sv ====
// Two-wide in-order retirement decision
// Writeback enables, retire count and redirect on exception or mispredict

module commit_select (
    input  logic                       head_valid_0,
    input  logic                       head_valid_1,
    input  logic                       head_ready_0,
    input  logic                       head_ready_1,
    input  rob_pkg::xlen_t             head_pc_0,
    input  rob_pkg::arch_reg_t         head_arch_reg_0,
    input  rob_pkg::arch_reg_t         head_arch_reg_1,
    input  rob_pkg::phys_reg_t         head_phys_reg_0,
    input  rob_pkg::phys_reg_t         head_phys_reg_1,
    input  rob_pkg::xlen_t             head_result_0,
    input  rob_pkg::xlen_t             head_result_1,
    input  logic                       head_exception_0,
    input  logic                       head_exception_1,
    input  commit_pkg::exc_code_e      head_exc_code_0,
    input  logic                       head_mispredict_0,
    input  logic                       head_mispredict_1,
    input  rob_pkg::xlen_t             head_target_0,
    output logic                       commit_valid_0,
    output logic                       commit_valid_1,
    output rob_pkg::arch_reg_t         commit_arch_reg_0,
    output rob_pkg::arch_reg_t         commit_arch_reg_1,
    output rob_pkg::phys_reg_t         commit_phys_reg_0,
    output rob_pkg::phys_reg_t         commit_phys_reg_1,
    output rob_pkg::xlen_t             commit_result_0,
    output rob_pkg::xlen_t             commit_result_1,
    output logic                       rf_write_en_0,
    output logic                       rf_write_en_1,
    output logic [1:0]                 retire_count,
    output logic                       redirect_valid,
    output commit_pkg::redirect_kind_e redirect_kind,
    output rob_pkg::xlen_t             redirect_pc,
    output commit_pkg::exc_code_e      redirect_exc_code
);
    import rob_pkg::*;
    import commit_pkg::*;

    logic done_0;
    logic done_1;
    logic special_0;
    logic special_1;

    assign done_0    = head_valid_0 && head_ready_0;
    assign done_1    = head_valid_1 && head_ready_1;
    assign special_0 = head_exception_0 || head_mispredict_0;
    assign special_1 = head_exception_1 || head_mispredict_1;

    // A special entry always retires by itself in slot 0
    assign commit_valid_0 = done_0;
    assign commit_valid_1 = done_0 && done_1 && !special_0 && !special_1;
    assign retire_count   = {1'b0, commit_valid_0} + {1'b0, commit_valid_1};

    assign commit_arch_reg_0 = head_arch_reg_0;
    assign commit_arch_reg_1 = head_arch_reg_1;
    assign commit_phys_reg_0 = head_phys_reg_0;
    assign commit_phys_reg_1 = head_phys_reg_1;
    assign commit_result_0   = head_result_0;
    assign commit_result_1   = head_result_1;

    // x0 never written, faulting entries leave no state behind
    assign rf_write_en_0 = done_0 && !head_exception_0 && (head_arch_reg_0 != arch_reg_t'(0));
    assign rf_write_en_1 = commit_valid_1 && (head_arch_reg_1 != arch_reg_t'(0));

    // Exception wins over mispredict on the same entry
    assign redirect_valid = done_0 && special_0;

    always_comb begin
        redirect_kind     = REDIRECT_NONE;
        redirect_pc       = head_target_0;
        redirect_exc_code = EXC_NONE;
        if (redirect_valid && head_exception_0) begin
            redirect_kind     = REDIRECT_EXCEPTION;
            redirect_pc       = head_pc_0;
            redirect_exc_code = head_exc_code_0;
        end else if (redirect_valid) begin
            redirect_kind     = REDIRECT_MISPREDICT;
        end
    end

endmodule

// ==== hdl/rob_entry_store.sv ====
// Per-entry ROB fields with valid and ready state
// Allocation and completion writes, retirement clears, head read ports

module rob_entry_store (
    input  logic                   clk,
    input  logic                   rst_n,
    input  rob_pkg::rob_id_t       tail_ptr,
    input  rob_pkg::rob_id_t       head_ptr,
    input  logic                   flush,
    input  logic [1:0]             retire_count,
    input  logic                   alloc_valid_0,
    input  logic                   alloc_valid_1,
    input  rob_pkg::xlen_t         alloc_pc_0,
    input  rob_pkg::xlen_t         alloc_pc_1,
    input  rob_pkg::arch_reg_t     alloc_arch_reg_0,
    input  rob_pkg::arch_reg_t     alloc_arch_reg_1,
    input  rob_pkg::phys_reg_t     alloc_phys_reg_0,
    input  rob_pkg::phys_reg_t     alloc_phys_reg_1,
    input  logic                   complete_valid,
    input  rob_pkg::rob_id_t       complete_rob_id,
    input  rob_pkg::xlen_t         complete_result,
    input  logic                   complete_exception,
    input  commit_pkg::exc_code_e  complete_exc_code,
    input  logic                   complete_mispredict,
    input  rob_pkg::xlen_t         complete_target,
    output logic                   head_valid_0,
    output logic                   head_valid_1,
    output logic                   head_ready_0,
    output logic                   head_ready_1,
    output rob_pkg::xlen_t         head_pc_0,
    output rob_pkg::arch_reg_t     head_arch_reg_0,
    output rob_pkg::arch_reg_t     head_arch_reg_1,
    output rob_pkg::phys_reg_t     head_phys_reg_0,
    output rob_pkg::phys_reg_t     head_phys_reg_1,
    output rob_pkg::xlen_t         head_result_0,
    output rob_pkg::xlen_t         head_result_1,
    output logic                   head_exception_0,
    output logic                   head_exception_1,
    output commit_pkg::exc_code_e  head_exc_code_0,
    output logic                   head_mispredict_0,
    output logic                   head_mispredict_1,
    output rob_pkg::xlen_t         head_target_0
);
    import rob_pkg::*;

    logic [ROB_DEPTH-1:0]  valid_q;
    logic [ROB_DEPTH-1:0]  ready_q;
    xlen_t                 pc_q        [ROB_DEPTH];
    arch_reg_t             arch_reg_q  [ROB_DEPTH];
    phys_reg_t             phys_reg_q  [ROB_DEPTH];
    xlen_t                 result_q    [ROB_DEPTH];
    logic                  exception_q [ROB_DEPTH];
    commit_pkg::exc_code_e exc_code_q  [ROB_DEPTH];
    logic                  mispred_q   [ROB_DEPTH];
    xlen_t                 target_q    [ROB_DEPTH];
    rob_id_t               tail_next;
    rob_id_t               head_next;
    logic                  complete_hit;

    assign tail_next    = tail_ptr + rob_id_t'(1);
    assign head_next    = head_ptr + rob_id_t'(1);
    assign complete_hit = complete_valid && valid_q[complete_rob_id];

    // ======================================================================
    // Valid and ready bits
    // ======================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
            ready_q <= '0;
        end else if (flush) begin
            valid_q <= '0;
            ready_q <= '0;
        end else begin
            if (complete_hit) begin
                ready_q[complete_rob_id] <= 1'b1;
            end
            if (retire_count != 2'd0) begin
                valid_q[head_ptr] <= 1'b0;
            end
            if (retire_count == 2'd2) begin
                valid_q[head_next] <= 1'b0;
            end
            // New entries wait for their own completion
            if (alloc_valid_0) begin
                valid_q[tail_ptr] <= 1'b1;
                ready_q[tail_ptr] <= 1'b0;
            end
            if (alloc_valid_1) begin
                valid_q[tail_next] <= 1'b1;
                ready_q[tail_next] <= 1'b0;
            end
        end
    end

    // ======================================================================
    // Payload fields
    // ======================================================================
    always_ff @(posedge clk) begin
        if (alloc_valid_0) begin
            pc_q[tail_ptr]       <= alloc_pc_0;
            arch_reg_q[tail_ptr] <= alloc_arch_reg_0;
            phys_reg_q[tail_ptr] <= alloc_phys_reg_0;
        end
        if (alloc_valid_1) begin
            pc_q[tail_next]       <= alloc_pc_1;
            arch_reg_q[tail_next] <= alloc_arch_reg_1;
            phys_reg_q[tail_next] <= alloc_phys_reg_1;
        end
        if (complete_hit) begin
            result_q[complete_rob_id]    <= complete_result;
            exception_q[complete_rob_id] <= complete_exception;
            exc_code_q[complete_rob_id]  <= complete_exc_code;
            mispred_q[complete_rob_id]   <= complete_mispredict;
            target_q[complete_rob_id]    <= complete_target;
        end
    end

    // Oldest two entries
    assign head_valid_0      = valid_q[head_ptr];
    assign head_valid_1      = valid_q[head_next];
    assign head_ready_0      = ready_q[head_ptr];
    assign head_ready_1      = ready_q[head_next];
    assign head_pc_0         = pc_q[head_ptr];
    assign head_arch_reg_0   = arch_reg_q[head_ptr];
    assign head_arch_reg_1   = arch_reg_q[head_next];
    assign head_phys_reg_0   = phys_reg_q[head_ptr];
    assign head_phys_reg_1   = phys_reg_q[head_next];
    assign head_result_0     = result_q[head_ptr];
    assign head_result_1     = result_q[head_next];
    assign head_exception_0  = exception_q[head_ptr];
    assign head_exception_1  = exception_q[head_next];
    assign head_exc_code_0   = exc_code_q[head_ptr];
    assign head_mispredict_0 = mispred_q[head_ptr];
    assign head_mispredict_1 = mispred_q[head_next];
    assign head_target_0     = target_q[head_ptr];

endmodule

// ==== hdl/rob_pointer_ctrl.sv ====
// Head and tail pointers and occupancy of the ROB
// Flush recovery and the registered credit return to rename

module rob_pointer_ctrl (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                alloc_valid_0,
    input  logic                alloc_valid_1,
    input  logic [1:0]          retire_count,
    input  logic                flush,
    output rob_pkg::rob_id_t    head_ptr,
    output rob_pkg::rob_id_t    tail_ptr,
    output rob_pkg::rob_count_t occupancy,
    output rob_pkg::rob_count_t credit_return
);
    import rob_pkg::*;

    rob_count_t alloc_count;
    rob_count_t retire_ext;
    rob_id_t    head_next;

    assign alloc_count = rob_count_t'(alloc_valid_0) + rob_count_t'(alloc_valid_1);
    assign retire_ext  = rob_count_t'(retire_count);
    assign head_next   = head_ptr + rob_id_t'(retire_count);

    // ======================================================================
    // Pointer and occupancy update
    // ======================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head_ptr  <= '0;
            tail_ptr  <= '0;
            occupancy <= '0;
        end else if (flush) begin
            // Everything younger than the redirecting entry is dropped,
            // including whatever rename allocated this cycle
            head_ptr  <= head_next;
            tail_ptr  <= head_next;
            occupancy <= '0;
        end else begin
            head_ptr  <= head_next;
            tail_ptr  <= tail_ptr + rob_id_t'(alloc_count);
            occupancy <= occupancy + alloc_count - retire_ext;
        end
    end

    // ======================================================================
    // Credit return
    // ======================================================================
    // One credit per freed entry, visible the cycle after the freeing edge.
    // On a flush the retired entry is part of the occupancy already
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credit_return <= '0;
        end else if (flush) begin
            credit_return <= occupancy + alloc_count;
        end else begin
            credit_return <= retire_ext;
        end
    end

endmodule

// ==== hdl/commit_pkg.sv ====
// Retirement outcome encodings
// Redirect kinds and exception codes seen at commit

package commit_pkg;

    // Why the front end is redirected at retirement
    typedef enum logic [1:0] {
        REDIRECT_NONE       = 2'd0,
        REDIRECT_EXCEPTION  = 2'd1,
        REDIRECT_MISPREDICT = 2'd2
    } redirect_kind_e;

    // Exception causes reported by execution
    typedef enum logic [3:0] {
        EXC_NONE          = 4'd0,
        EXC_ILLEGAL_INSTR = 4'd1,
        EXC_MISALIGNED    = 4'd2,
        EXC_LOAD_FAULT    = 4'd3,
        EXC_STORE_FAULT   = 4'd4,
        EXC_ECALL         = 4'd5
    } exc_code_e;

endpackage

// ==== hdl/rob_pkg.sv ====
// ROB geometry and field widths
// Index, count and payload types shared by the ROB modules

package rob_pkg;

    // ======================================================================
    // Geometry
    // ======================================================================
    localparam int ROB_DEPTH     = 16;
    localparam int ROB_ID_BITS   = 4;

    // ======================================================================
    // Payload widths
    // ======================================================================
    localparam int XLEN          = 32;
    localparam int ARCH_REG_BITS = 5;
    localparam int PHYS_REG_BITS = 6;

    // Entry index, wraps at ROB_DEPTH
    typedef logic [ROB_ID_BITS-1:0]   rob_id_t;

    // One extra bit so a full ROB can be counted
    typedef logic [ROB_ID_BITS:0]     rob_count_t;

    typedef logic [XLEN-1:0]          xlen_t;
    typedef logic [ARCH_REG_BITS-1:0] arch_reg_t;
    typedef logic [PHYS_REG_BITS-1:0] phys_reg_t;

endpackage
